//--- compile.f
+incdir+hw
hw/burst_mem_pkg.sv
hw/apb_decode.sv
hw/burst_master.sv
hw/burst_bram.sv
hw/line_result.sv
hw/burst_mem_top.sv
sim/tb_clock_gen.sv
sim/tb_burst_mem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_burst_mem
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and scan $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "test: failure reported in $(LOG)"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "test: run ended without a result"; exit 1; \
	else \
		echo "test: no failure found in $(LOG)"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_burst_mem.sv
// Directed testbench for the line-transfer engine; drives APB and checks line data and status
`timescale 1ns/100ps
`include "burst_mem_macros.svh"

module tb_burst_mem;

    logic        itf;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          n_errors = 0;
    int          n_checks = 0;
    int unsigned cycles = 0;
    logic [31:0] rng_state;
    logic [31:0] staged [`BM_BEATS];
    // Expected memory contents per line and word
    logic [31:0] sb [`BM_LINES][`BM_BEATS];

    tb_clock_gen u_clk (.itf(itf), .reset(reset));

    burst_mem_top uut (
        .itf(itf), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always @(posedge itf) cycles <= cycles + 1;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [7:0] ofs);
        return {24'h0, ofs};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Setup cycle followed by an access cycle sampled mid-cycle
    task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int n;
        n = 0;
        @(negedge itf);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge itf);
        penable = 1'b1;
        #1;
        check_flag(pready, 1'b1, "pready in access cycle");
        while (pready !== 1'b1 && n < 100) begin
            @(negedge itf);
            #1;
            n++;
        end
        if (pready !== 1'b1) begin
            abort_run("APB transfer timed out, pready stayed low for 100 cycles");
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge itf);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] ignored;
        apb_access(1'b1, addr, data, ignored, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        logic        err;
        int unsigned t0;
        t0 = cycles;
        apb_read(reg_addr(`BM_OFS_STATUS), st, err);
        while (st[0] && (cycles - t0) < 100) begin
            apb_read(reg_addr(`BM_OFS_STATUS), st, err);
        end
        if (st[0]) begin
            abort_run("Timeout: busy did not fall within 100 cycles");
        end
    endtask

    task automatic fill_wdata();
        logic err;
        for (int i = 0; i < `BM_BEATS; i++) begin
            staged[i] = next_rand();
            apb_write(reg_addr(`BM_OFS_WDATA) + 32'(4 * i), staged[i], err);
            check_flag(err, 1'b0, "pslverr on WDATA write");
        end
    endtask

    task automatic start_cmd(input logic [31:0] addr, input logic [1:0] bits,
                             input logic exp_err, input string what);
        logic err;
        apb_write(reg_addr(`BM_OFS_ADDR), addr, err);
        check_flag(err, 1'b0, "pslverr on ADDR write");
        apb_write(reg_addr(`BM_OFS_CTRL), {30'h0, bits}, err);
        check_flag(err, exp_err, what);
    endtask

    task automatic compare_rdata(input int line);
        logic [31:0] d;
        logic        err;
        for (int i = 0; i < `BM_BEATS; i++) begin
            apb_read(reg_addr(`BM_OFS_RDATA) + 32'(4 * i), d, err);
            check_word(d, sb[line][i], $sformatf("line %0d word %0d", line, i));
        end
    endtask

    task automatic write_line(input int line);
        fill_wdata();
        start_cmd(32'(line * `BM_LINE_BYTES), 2'b01, 1'b0, "pslverr on write start");
        wait_idle();
        for (int i = 0; i < `BM_BEATS; i++) begin
            sb[line][i] = staged[i];
        end
    endtask

    task automatic read_check(input int line);
        start_cmd(32'(line * `BM_LINE_BYTES), 2'b10, 1'b0, "pslverr on read start");
        wait_idle();
        compare_rdata(line);
    endtask

    task automatic test_reset_state();
        logic [31:0] st;
        logic        err;
        apb_read(reg_addr(`BM_OFS_STATUS), st, err);
        check_word(st, 32'h0, "STATUS after reset");
        read_check(0);
    endtask

    task automatic test_single_line();
        write_line(5);
        read_check(5);
    endtask

    // Line 5 was written earlier and must survive its neighbours
    task automatic test_neighbours();
        write_line(4);
        write_line(6);
        write_line(63);
        read_check(63);
        read_check(6);
        read_check(4);
        read_check(5);
    endtask

    task automatic test_start_while_busy();
        logic err;
        fill_wdata();
        start_cmd(32'(10 * `BM_LINE_BYTES), 2'b01, 1'b0, "pslverr on write start");
        apb_write(reg_addr(`BM_OFS_CTRL), 32'h2, err);
        check_flag(err, 1'b1, "pslverr on start while busy");
        wait_idle();
        for (int i = 0; i < `BM_BEATS; i++) begin
            sb[10][i] = staged[i];
        end
        read_check(10);
    endtask

    task automatic test_rejected_starts();
        logic [31:0] st;
        logic        err;
        start_cmd(32'd2048, 2'b01, 1'b1, "pslverr on start at 2048");
        apb_read(reg_addr(`BM_OFS_STATUS), st, err);
        check_flag(st[0], 1'b0, "busy after out-of-range start");
        start_cmd(32'hffff_ffe0, 2'b10, 1'b1, "pslverr on start far out of range");
        start_cmd(32'(3 * `BM_LINE_BYTES), 2'b11, 1'b1, "pslverr with both start bits");
        apb_read(reg_addr(`BM_OFS_STATUS), st, err);
        check_flag(st[0], 1'b0, "busy after both-bits start");
    endtask

    task automatic test_done_flag();
        logic [31:0] st;
        logic        err;
        apb_read(reg_addr(`BM_OFS_STATUS), st, err);
        check_flag(st[1], 1'b1, "done after transfer");
        start_cmd(32'(63 * `BM_LINE_BYTES), 2'b10, 1'b0, "pslverr on read start");
        apb_read(reg_addr(`BM_OFS_STATUS), st, err);
        check_flag(st[1], 1'b0, "done after new start");
        check_flag(st[0], 1'b1, "busy during read");
        wait_idle();
        apb_read(reg_addr(`BM_OFS_STATUS), st, err);
        check_flag(st[1], 1'b1, "done at end of read");
        compare_rdata(63);
    endtask

    initial begin
        int n;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 32'h0;
        pwdata    = 32'h0;
        rng_state = 32'd18994;
        n         = 0;
        for (int l = 0; l < `BM_LINES; l++) begin
            for (int i = 0; i < `BM_BEATS; i++) begin
                sb[l][i] = 32'h0;
            end
        end

        @(negedge itf);
        while (reset && n < 100) begin
            @(negedge itf);
            n++;
        end
        if (reset) begin
            abort_run("Reset never released");
        end

        test_reset_state();
        test_single_line();
        test_neighbours();
        test_start_while_busy();
        test_rejected_starts();
        test_done_flag();

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock of 8 ns period with synchronous reset held high for the first 8 cycles
`timescale 1ns/100ps

module tb_clock_gen (
    output logic itf,
    output logic reset
);

    initial begin
        itf = 1'b0;
        forever #4 itf = ~itf;
    end

    // Released on a falling edge like every other input
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge itf);
        @(negedge itf);
        reset = 1'b0;
    end

endmodule

//--- hw/burst_mem_top.sv
// Top level of the line-transfer engine joining decode, execute, memory and result stages
`timescale 1ns/100ps
`include "burst_mem_macros.svh"

module burst_mem_top (
    input  logic        itf,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    burst_mem_pkg::line_cmd_t cmd;
    burst_mem_pkg::mem_req_t  req;
    burst_mem_pkg::mem_rsp_t  rsp;
    burst_mem_pkg::beat_t     beat;
    logic [`BM_LINE_W-1:0]    wr_line;
    logic [`BM_LINE_W-1:0]    rd_line;
    logic                     line_done;
    logic                     busy;
    logic                     done;

    apb_decode u_decode (
        .itf(itf), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .busy(busy), .done(done), .rd_line(rd_line),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cmd(cmd), .wr_line(wr_line)
    );

    burst_master u_master (
        .itf(itf), .reset(reset),
        .cmd(cmd), .wr_line(wr_line), .rsp(rsp),
        .req(req), .beat(beat), .line_done(line_done)
    );

    burst_bram u_bram (
        .itf(itf), .reset(reset),
        .req(req), .rsp(rsp)
    );

    line_result u_result (
        .itf(itf), .reset(reset),
        .cmd_start(cmd.start), .beat(beat), .line_done(line_done),
        .rd_line(rd_line), .busy(busy), .done(done)
    );

endmodule

//--- hw/line_result.sv
// Result stage that assembles returned read beats into a line and keeps busy and done status
`timescale 1ns/100ps
`include "burst_mem_macros.svh"

module line_result (
    input  logic                  itf,
    input  logic                  reset,
    input  logic                  cmd_start,
    input  burst_mem_pkg::beat_t  beat,
    input  logic                  line_done,
    output logic [`BM_LINE_W-1:0] rd_line,
    output logic                  busy,
    output logic                  done
);

    // Beats land by index, order on the bus does not matter
    always_ff @(posedge itf) begin
        if (beat.valid) begin
            rd_line[beat.idx * `BM_BUS_W +: `BM_BUS_W] <= beat.data;
        end
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            if (line_done) begin
                busy <= 1'b0;
            end else if (cmd_start) begin
                busy <= 1'b1;
            end
            // Sticky until the next accepted start
            if (cmd_start) begin
                done <= 1'b0;
            end else if (line_done) begin
                done <= 1'b1;
            end
        end
    end

endmodule

//--- hw/burst_bram.sv
// Single-port 64-bit memory serving eight-beat bursts on the native bus
`timescale 1ns/100ps
`include "burst_mem_macros.svh"

module burst_bram (
    input  logic                    itf,
    input  logic                    reset,
    input  burst_mem_pkg::mem_req_t req,
    output burst_mem_pkg::mem_rsp_t rsp
);

    localparam int idx_w = `BM_WORD_IDX_W;

    burst_mem_pkg::bram_state_t state, next_state;

    logic [`BM_WORD_W-1:0]     mem [`BM_DEPTH];
    logic [`BM_WORD_IDX_W-1:0] base_q;
    logic [`BM_BEAT_IDX_W-1:0] cnt;
    logic [`BM_BUS_W-1:0]      lo_q;
    logic [`BM_WORD_W-1:0]     rd_word;
    logic [`BM_WORD_IDX_W-1:0] wr_addr;
    logic [`BM_WORD_IDX_W-1:0] rd_addr;
    logic                      store_addr;
    logic                      store_lo;
    logic                      write_word;
    logic                      fetch;

    // Two beats per word
    assign wr_addr = base_q + idx_w'(cnt[`BM_BEAT_IDX_W-1:1]);
    // Next word is fetched while its predecessor's upper half goes out
    assign rd_addr = base_q + idx_w'(cnt[`BM_BEAT_IDX_W-1:1]) + idx_w'(cnt[0]);

    always_comb begin
        next_state = state;
        store_addr = 1'b0;
        store_lo   = 1'b0;
        write_word = 1'b0;
        fetch      = 1'b0;
        rsp        = '0;
        case (state)
            burst_mem_pkg::bram_idle: begin
                if (req.read_en || req.write_en) begin
                    next_state = burst_mem_pkg::bram_addr;
                end
            end
            burst_mem_pkg::bram_addr: begin
                if (req.addr_on) begin
                    rsp.resp   = 1'b1;
                    store_addr = 1'b1;
                    next_state = req.write_en ? burst_mem_pkg::bram_write
                                              : burst_mem_pkg::bram_fetch;
                end
            end
            burst_mem_pkg::bram_write: begin
                if (req.data_on) begin
                    rsp.resp   = 1'b1;
                    store_lo   = !cnt[0];
                    write_word = cnt[0];
                    if (&cnt) begin
                        next_state = burst_mem_pkg::bram_idle;
                    end
                end
            end
            burst_mem_pkg::bram_fetch: begin
                fetch      = 1'b1;
                next_state = burst_mem_pkg::bram_read;
            end
            burst_mem_pkg::bram_read: begin
                rsp.resp  = 1'b1;
                rsp.rdata = cnt[0] ? rd_word[`BM_BUS_W +: `BM_BUS_W] : rd_word[`BM_BUS_W-1:0];
                fetch     = cnt[0];
                if (&cnt) begin
                    next_state = burst_mem_pkg::bram_idle;
                end
            end
            default: begin
                next_state = burst_mem_pkg::bram_idle;
            end
        endcase
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            state <= burst_mem_pkg::bram_idle;
            cnt   <= '0;
            for (int i = 0; i < `BM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            state <= next_state;
            if (store_addr) begin
                cnt <= '0;
            end else if (rsp.resp) begin
                cnt <= cnt + 1'b1;
            end
            // Commit on the upper half
            if (write_word) begin
                mem[wr_addr] <= {req.ad_bus, lo_q};
            end
        end
    end

    always_ff @(posedge itf) begin
        if (store_addr) begin
            base_q <= req.ad_bus[`BM_WORD_SHIFT +: `BM_WORD_IDX_W];
        end
        if (store_lo) begin
            lo_q <= req.ad_bus;
        end
        if (fetch) begin
            rd_word <= mem[rd_addr];
        end
    end

    no_early_data_chk: assert property (
        @(posedge itf) disable iff (reset)
        (state == burst_mem_pkg::bram_idle || state == burst_mem_pkg::bram_addr) |-> !req.data_on
    );

endmodule

//--- hw/burst_master.sv
// Execute stage that runs the address phase and eight data beats of a line burst
`timescale 1ns/100ps
`include "burst_mem_macros.svh"

module burst_master (
    input  logic                     itf,
    input  logic                     reset,
    input  burst_mem_pkg::line_cmd_t cmd,
    input  logic [`BM_LINE_W-1:0]    wr_line,
    input  burst_mem_pkg::mem_rsp_t  rsp,
    output burst_mem_pkg::mem_req_t  req,
    output burst_mem_pkg::beat_t     beat,
    output logic                     line_done
);

    burst_mem_pkg::master_state_t state, next_state;

    logic                      is_write;
    logic [`BM_BEAT_IDX_W-1:0] cnt;
    logic [`BM_LINE_IDX_W-1:0] line_q;
    logic [`BM_LINE_W-1:0]     wbuf;
    logic                      start_ok;
    logic                      beat_ok;

    assign start_ok = state == burst_mem_pkg::mst_idle && cmd.start;
    assign beat_ok  = rsp.resp && (state == burst_mem_pkg::mst_write ||
                                   state == burst_mem_pkg::mst_read);

    always_ff @(posedge itf) begin
        if (reset) begin
            state    <= burst_mem_pkg::mst_idle;
            is_write <= 1'b0;
            cnt      <= '0;
        end else begin
            state <= next_state;
            if (start_ok) begin
                is_write <= cmd.write;
                cnt      <= '0;
            end else if (beat_ok) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Line held for the whole burst
    always_ff @(posedge itf) begin
        if (start_ok) begin
            line_q <= cmd.line;
            wbuf   <= wr_line;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            burst_mem_pkg::mst_idle: begin
                if (cmd.start) begin
                    next_state = burst_mem_pkg::mst_addr;
                end
            end
            burst_mem_pkg::mst_addr: begin
                if (rsp.resp) begin
                    next_state = is_write ? burst_mem_pkg::mst_write : burst_mem_pkg::mst_read;
                end
            end
            burst_mem_pkg::mst_write, burst_mem_pkg::mst_read: begin
                if (beat_ok && &cnt) begin
                    next_state = burst_mem_pkg::mst_done;
                end
            end
            default: begin
                next_state = burst_mem_pkg::mst_idle;
            end
        endcase
    end

    always_comb begin
        req          = '0;
        req.read_en  = !is_write && (state == burst_mem_pkg::mst_addr ||
                                     state == burst_mem_pkg::mst_read);
        req.write_en = is_write && (state == burst_mem_pkg::mst_addr ||
                                    state == burst_mem_pkg::mst_write);
        req.addr_on  = state == burst_mem_pkg::mst_addr;
        req.data_on  = state == burst_mem_pkg::mst_write;
        if (state == burst_mem_pkg::mst_addr) begin
            // Line index to byte address
            req.ad_bus = {{(`BM_BUS_W - `BM_LINE_IDX_W - `BM_LINE_SHIFT){1'b0}},
                          line_q, {`BM_LINE_SHIFT{1'b0}}};
        end else if (state == burst_mem_pkg::mst_write) begin
            req.ad_bus = wbuf[cnt * `BM_BUS_W +: `BM_BUS_W];
        end
    end

    assign beat.valid = state == burst_mem_pkg::mst_read && rsp.resp;
    assign beat.idx   = cnt;
    assign beat.data  = rsp.rdata;
    assign line_done  = state == burst_mem_pkg::mst_done;

    // Memory answers only inside a burst with exactly one direction enabled
    rw_excl_chk: assert property (
        @(posedge itf) disable iff (reset) rsp.resp |-> (req.read_en ^ req.write_en)
    );

endmodule

//--- hw/apb_decode.sv
// APB slave with the register map and write-line buffer; checks and issues line commands
`timescale 1ns/100ps
`include "burst_mem_macros.svh"

module apb_decode (
    input  logic                     itf,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              paddr,
    input  logic [31:0]              pwdata,
    input  logic                     busy,
    input  logic                     done,
    input  logic [`BM_LINE_W-1:0]    rd_line,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    output burst_mem_pkg::line_cmd_t cmd,
    output logic [`BM_LINE_W-1:0]    wr_line
);

    // Eight-word windows for WDATA and RDATA
    localparam logic [7:0] win_mask = 8'(~(`BM_BEATS * (`BM_BUS_W / 8) - 1));

    logic [7:0]                ofs;
    logic                      page_hit;
    logic                      acc_wr;
    logic                      wdata_hit;
    logic                      rdata_hit;
    logic [`BM_BEAT_IDX_W-1:0] word_sel;
    logic [31:0]               addr_q;
    logic                      ctrl_wr;
    logic                      start_req;
    logic                      both_set;
    logic                      out_of_range;
    logic                      reject;

    assign ofs       = paddr[7:0];
    assign page_hit  = paddr[31:8] == '0;
    assign acc_wr    = psel && penable && pwrite && page_hit;
    assign wdata_hit = (ofs & win_mask) == `BM_OFS_WDATA;
    assign rdata_hit = (ofs & win_mask) == `BM_OFS_RDATA;
    assign word_sel  = paddr[2 +: `BM_BEAT_IDX_W];

    // Start checks
    assign ctrl_wr      = acc_wr && ofs == `BM_OFS_CTRL;
    assign start_req    = pwdata[0] || pwdata[1];
    assign both_set     = pwdata[0] && pwdata[1];
    assign out_of_range = addr_q >= `BM_ADDR_LIMIT;
    assign reject       = ctrl_wr && start_req && (busy || both_set || out_of_range);

    assign cmd.start = ctrl_wr && start_req && !reject;
    assign cmd.write = pwdata[0];
    assign cmd.line  = addr_q[`BM_LINE_SHIFT +: `BM_LINE_IDX_W];

    // Zero wait states
    assign pready  = 1'b1;
    assign pslverr = reject;

    always_ff @(posedge itf) begin
        if (reset) begin
            addr_q <= '0;
        end else if (acc_wr && ofs == `BM_OFS_ADDR) begin
            // Line aligned
            addr_q <= pwdata & ~32'(`BM_LINE_BYTES - 1);
        end
    end

    always_ff @(posedge itf) begin
        if (acc_wr && wdata_hit) begin
            wr_line[word_sel * `BM_BUS_W +: `BM_BUS_W] <= pwdata;
        end
    end

    always_comb begin
        prdata = '0;
        if (page_hit) begin
            if (ofs == `BM_OFS_ADDR) begin
                prdata = addr_q;
            end else if (ofs == `BM_OFS_STATUS) begin
                prdata = {{(`BM_BUS_W - 2){1'b0}}, done, busy};
            end else if (wdata_hit) begin
                prdata = wr_line[word_sel * `BM_BUS_W +: `BM_BUS_W];
            end else if (rdata_hit) begin
                prdata = rd_line[word_sel * `BM_BUS_W +: `BM_BUS_W];
            end
        end
    end

    // Never a start while busy, and the result stage reports busy right after
    start_busy_chk: assert property (
        @(posedge itf) disable iff (reset) cmd.start |-> !busy ##1 busy
    );

endmodule

//--- hw/burst_mem_pkg.sv
// Bus structs, command and beat types and FSM states shared by the line-transfer engine
`include "burst_mem_macros.svh"

package burst_mem_pkg;

    // Controller to memory, address and data share ad_bus
    typedef struct packed {
        logic                 read_en;
        logic                 write_en;
        logic                 addr_on;
        logic                 data_on;
        logic [`BM_BUS_W-1:0] ad_bus;
    } mem_req_t;

    // Memory to controller
    typedef struct packed {
        logic                 resp;
        logic [`BM_BUS_W-1:0] rdata;
    } mem_rsp_t;

    // Decode to execute
    typedef struct packed {
        logic                      start;
        logic                      write;
        logic [`BM_LINE_IDX_W-1:0] line;
    } line_cmd_t;

    // One returned read beat
    typedef struct packed {
        logic                      valid;
        logic [`BM_BEAT_IDX_W-1:0] idx;
        logic [`BM_BUS_W-1:0]      data;
    } beat_t;

    typedef enum logic [2:0] {
        bram_idle,
        bram_addr,
        bram_write,
        bram_fetch,
        bram_read
    } bram_state_t;

    typedef enum logic [2:0] {
        mst_idle,
        mst_addr,
        mst_write,
        mst_read,
        mst_done
    } master_state_t;

endpackage

//--- hw/burst_mem_macros.svh
// Sizes and APB register offsets of the line-transfer engine, included by the package and RTL
`ifndef BURST_MEM_MACROS_SVH
`define BURST_MEM_MACROS_SVH

// Native bus and memory geometry
`define BM_BUS_W        32
`define BM_WORD_W       64
`define BM_BEATS        8
`define BM_DEPTH        256
`define BM_LINE_BYTES   32

// Derived sizes
`define BM_LINE_W       (`BM_BUS_W * `BM_BEATS)
`define BM_ADDR_LIMIT   (`BM_DEPTH * (`BM_WORD_W / 8))
`define BM_LINES        (`BM_ADDR_LIMIT / `BM_LINE_BYTES)
`define BM_LINE_IDX_W   ($clog2(`BM_LINES))
`define BM_LINE_SHIFT   ($clog2(`BM_LINE_BYTES))
`define BM_WORD_IDX_W   ($clog2(`BM_DEPTH))
`define BM_WORD_SHIFT   ($clog2(`BM_WORD_W / 8))
`define BM_BEAT_IDX_W   ($clog2(`BM_BEATS))

// APB register offsets
`define BM_OFS_CTRL     8'h00
`define BM_OFS_ADDR     8'h04
`define BM_OFS_STATUS   8'h08
`define BM_OFS_WDATA    8'h20
`define BM_OFS_RDATA    8'h40

`endif
